/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := tb_clock_ctrl
FILELIST := build.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(wildcard src/*.sv test/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without passing"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

/* build.f */
src/clock_ctrl_pkg.sv
src/cmd_deser.sv
src/clock_cmd_decoder.sv
src/clock_presence_monitor.sv
src/status_generate.sv
src/clock_ctrl_top.sv
test/clock_ctrl_asserts.sv
test/tb_clock_ctrl.sv

/* src/clock_cmd_decoder.sv */
`timescale 1ns/1ps

module clock_cmd_decoder #(
    parameter clock_ctrl_pkg::cmd_addr_t CLK_ADDR = 'h728, // base address
    parameter clock_ctrl_pkg::cmd_addr_t CLK_MASK = 'h7fe  // address mask
) (
    input  logic                      mclk,
    input  logic                      rst,
    input  clock_ctrl_pkg::cmd_byte_t cmd_ad_i,    // command bus byte
    input  logic                      cmd_stb_i,   // strobe with first byte
    output clock_ctrl_pkg::clk_ctrl_t ctrl_o,      // control register
    output logic                      status_we_o, // status-mode write pulse
    output clock_ctrl_pkg::cmd_byte_t status_wd_o  // status-mode write data
);

    import clock_ctrl_pkg::*;

    logic       cmd_a;      // local offset
    cmd_data_t  cmd_data;   // decoded data word
    logic       cmd_we;     // decoded write
    logic       set_ctrl;   // write to control offset
    clk_ctrl_t  ctrl_q;

    cmd_deser #(
        .ADDR      (CLK_ADDR),
        .ADDR_MASK (CLK_MASK)
    ) cmd_deser_i (
        .mclk   (mclk),
        .rst    (rst),
        .ad_i   (cmd_ad_i),
        .stb_i  (cmd_stb_i),
        .addr_o (cmd_a),
        .data_o (cmd_data),
        .we_o   (cmd_we)
    );

    // route by offset
    assign set_ctrl    = cmd_we & (cmd_a == CLK_CNTRL);
    assign status_we_o = cmd_we & (cmd_a == CLK_STATUS); // same cycle as write
    assign status_wd_o = cmd_data[7:0];                  // mode + sequence

    // control word: pwrdwn in bits 6..3, clk_rst in bits 2..0
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ctrl_q <= '0;
        end else if (set_ctrl) begin
            ctrl_q <= clk_ctrl_t'(cmd_data[6:0]);
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

/* src/clock_ctrl_pkg.sv */
package clock_ctrl_pkg;

    // bus and command widths
    typedef logic [7:0]  cmd_byte_t;   // one byte on command or status bus
    typedef logic [15:0] cmd_addr_t;   // full command address
    typedef logic [15:0] cmd_data_t;   // command data, two bytes

    // control word, low 7 data bits of a control write
    typedef struct packed {
        logic [3:0] pwrdwn;            // power-down levels to external sources
        logic [2:0] clk_rst;           // resets of monitored inputs
    } clk_ctrl_t;

    // status payload, msb field first
    typedef struct packed {
        logic [2:0] alive;             // monitored clocks running
        logic [3:0] pwrdwn;            // echo of power-down levels
        logic [1:0] extra;             // extra bits from outside
    } status_payload_t;

    // status-mode code, status-write data bits 7..6
    typedef logic [1:0] status_mode_t;

    localparam status_mode_t MODE_OFF   = 2'd0; // no packets
    localparam status_mode_t MODE_ONCE  = 2'd1; // single packet
    localparam status_mode_t MODE_AUTO  = 2'd2; // send on payload change
    localparam status_mode_t MODE_AUTO2 = 2'd3; // same as MODE_AUTO

    // sequence number, status-write data bits 5..0
    typedef logic [5:0] status_seq_t;

    // status serializer states
    typedef enum logic [1:0] {
        IDLE,                          // waiting for a pending request
        REQ,                           // rq raised, address byte on bus
        BYTE1,                         // {seq, payload[1:0]}
        BYTE2                          // {0, payload[8:2]}
    } status_state_e;

    // local register offsets (address bit 0)
    localparam logic CLK_CNTRL  = 1'b0;
    localparam logic CLK_STATUS = 1'b1;

endpackage

/* src/clock_ctrl_top.sv */
`timescale 1ns/1ps

module clock_ctrl_top #(
    parameter clock_ctrl_pkg::cmd_addr_t CLK_ADDR        = 'h728, // ..'h729
    parameter clock_ctrl_pkg::cmd_addr_t CLK_MASK        = 'h7fe,
    parameter clock_ctrl_pkg::cmd_byte_t STATUS_REG_ADDR = 'h3a,
    parameter int                        WINDOW_LOG2     = 8      // 256-cycle window
) (
    input  logic                      mclk,
    input  logic                      rst,
    input  clock_ctrl_pkg::cmd_byte_t cmd_ad_i,       // command bus
    input  logic                      cmd_stb_i,
    output clock_ctrl_pkg::cmd_byte_t status_ad_o,    // status bus
    output logic                      status_rq_o,
    input  logic                      status_start_i,
    input  logic                      memclk_i,       // external memory clock
    input  logic                      ffclk0_i,       // sensor clock 0
    input  logic                      ffclk1_i,       // sensor clock 1
    input  logic [1:0]                extra_status_i, // from outside, into payload
    output logic [3:0]                pwrdwn_o,       // to clock sources
    output logic                      time_ref_o
);

    import clock_ctrl_pkg::*;

    clk_ctrl_t  ctrl;
    logic       status_we;
    cmd_byte_t  status_wd;
    logic [2:0] alive;

    clock_cmd_decoder #(
        .CLK_ADDR (CLK_ADDR),
        .CLK_MASK (CLK_MASK)
    ) clock_cmd_decoder_i (
        .mclk        (mclk),
        .rst         (rst),
        .cmd_ad_i    (cmd_ad_i),
        .cmd_stb_i   (cmd_stb_i),
        .ctrl_o      (ctrl),
        .status_we_o (status_we),
        .status_wd_o (status_wd)
    );

    clock_presence_monitor #(
        .WINDOW_LOG2 (WINDOW_LOG2)
    ) clock_presence_monitor_i (
        .mclk       (mclk),
        .rst        (rst),
        .mon_clk_i  ({ffclk1_i, ffclk0_i, memclk_i}),
        .clk_rst_i  (ctrl.clk_rst),
        .alive_o    (alive),
        .time_ref_o (time_ref_o)
    );

    status_generate #(
        .STATUS_REG_ADDR (STATUS_REG_ADDR)
    ) status_generate_i (
        .mclk      (mclk),
        .rst       (rst),
        .we_i      (status_we),
        .wd_i      (status_wd),
        .payload_i ({alive, ctrl.pwrdwn, extra_status_i}), // alive, pwrdwn, extra
        .ad_o      (status_ad_o),
        .rq_o      (status_rq_o),
        .start_i   (status_start_i)
    );

    assign pwrdwn_o = ctrl.pwrdwn;

endmodule

/* src/clock_presence_monitor.sv */
`timescale 1ns/1ps

module clock_presence_monitor #(
    parameter int WINDOW_LOG2 = 8 // window length is 2**WINDOW_LOG2 mclk cycles
) (
    input  logic       mclk,
    input  logic       rst,
    input  logic [2:0] mon_clk_i,  // [0] memclk, [1] ffclk0, [2] ffclk1
    input  logic [2:0] clk_rst_i,  // per-input reset, mclk domain
    output logic [2:0] alive_o,    // input toggled during last window
    output logic       time_ref_o  // slow time reference
);

    logic [WINDOW_LOG2-1:0] win_cnt_q;  // free-running window counter
    logic                   win_end;    // last cycle of a window

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            win_cnt_q <= '0;
        end else begin
            win_cnt_q <= win_cnt_q + 1'b1;
        end
    end

    assign win_end    = &win_cnt_q;
    assign time_ref_o = win_cnt_q[WINDOW_LOG2-1]; // period 2**WINDOW_LOG2

    for (genvar i = 0; i < 3; i++) begin : g_mon
        logic       tgl_q;    // toggles in the monitored domain
        logic [1:0] sync_q;   // two-stage synchronizer
        logic       last_q;   // previous synchronized value
        logic       changed;  // synchronized flag moved this cycle
        logic       seen_q;   // change seen in current window
        logic       alive_q;

        // toggle flip-flop, held at 0 while its reset is set
        always_ff @(posedge mon_clk_i[i] or posedge clk_rst_i[i]) begin
            if (clk_rst_i[i]) begin
                tgl_q <= 1'b0;
            end else begin
                tgl_q <= ~tgl_q;
            end
        end

        // crossing into mclk
        always_ff @(posedge mclk or posedge rst) begin
            if (rst) begin
                sync_q <= '0;
                last_q <= 1'b0;
            end else begin
                sync_q <= {sync_q[0], tgl_q};
                last_q <= sync_q[1];
            end
        end

        assign changed = sync_q[1] ^ last_q;

        // edge-seen latch and alive bit, sampled once per window
        always_ff @(posedge mclk or posedge rst) begin
            if (rst) begin
                seen_q  <= 1'b0;
                alive_q <= 1'b0;
            end else if (clk_rst_i[i]) begin
                seen_q  <= 1'b0;           // input held in reset
                alive_q <= 1'b0;
            end else if (win_end) begin
                alive_q <= seen_q | changed; // include a change on the last cycle
                seen_q  <= 1'b0;
            end else if (changed) begin
                seen_q  <= 1'b1;
            end
        end

        assign alive_o[i] = alive_q;
    end

endmodule

/* src/cmd_deser.sv */
`timescale 1ns/1ps

module cmd_deser #(
    parameter clock_ctrl_pkg::cmd_addr_t ADDR      = 'h728, // block base address
    parameter clock_ctrl_pkg::cmd_addr_t ADDR_MASK = 'h7fe  // bits compared against base
) (
    input  logic                      mclk,
    input  logic                      rst,
    input  clock_ctrl_pkg::cmd_byte_t ad_i,   // byte-serial address/data
    input  logic                      stb_i,  // high with first byte only
    output logic                      addr_o, // local offset from address bit 0
    output clock_ctrl_pkg::cmd_data_t data_o, // {data high, data low}
    output logic                      we_o    // one-cycle write strobe
);

    import clock_ctrl_pkg::*;

    // bytes arrive as addr low, addr high, data low, data high

    logic [2:0]   pos_q;      // byte position, one-hot shifting
    cmd_byte_t    sr_q [3];   // last three bytes, [2] is oldest
    cmd_addr_t    cmd_addr;   // assembled address
    logic         addr_hit;   // address matches base under mask
    logic         last_byte;  // fourth byte is on ad_i now

    // pos_q[0] set while addr high is on the bus, pos_q[2] while data high is
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pos_q <= '0;
        end else begin
            pos_q <= {pos_q[1:0], stb_i};
        end
    end

    // free-shifting byte history
    always_ff @(posedge mclk) begin
        sr_q[2] <= sr_q[1];
        sr_q[1] <= sr_q[0];
        sr_q[0] <= ad_i;
    end

    // sr_q[2] addr low, sr_q[1] addr high, sr_q[0] data low at the fourth byte
    assign cmd_addr  = {sr_q[1], sr_q[2]};
    assign addr_hit  = ((cmd_addr ^ ADDR) & ADDR_MASK) == '0;
    assign last_byte = pos_q[2];

    // write strobe one cycle after the fourth byte
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            we_o <= 1'b0;
        end else begin
            we_o <= last_byte & addr_hit; // non-matching commands dropped
        end
    end

    // payload registers loaded on the last byte
    always_ff @(posedge mclk) begin
        if (last_byte) begin
            addr_o <= cmd_addr[0];        // local offset
            data_o <= {ad_i, sr_q[0]};    // data high from the bus
        end
    end

endmodule

/* src/status_generate.sv */
`timescale 1ns/1ps

module status_generate #(
    parameter clock_ctrl_pkg::cmd_byte_t STATUS_REG_ADDR = 'h3a // first byte of each packet
) (
    input  logic                            mclk,
    input  logic                            rst,
    input  logic                            we_i,      // status-mode write
    input  clock_ctrl_pkg::cmd_byte_t       wd_i,      // {mode, seq}
    input  clock_ctrl_pkg::status_payload_t payload_i, // current status
    output clock_ctrl_pkg::cmd_byte_t       ad_o,      // status bus byte
    output logic                            rq_o,      // request to send
    input  logic                            start_i    // grant, one cycle
);

    import clock_ctrl_pkg::*;

    status_mode_t    mode_q;    // current mode
    status_seq_t     seq_q;     // sequence number sent in byte 1
    logic            once_q;    // send-once request pending
    status_payload_t snap_q;    // payload being / last sent
    status_state_e   state_q;
    logic            auto_mode;
    logic            send_req;  // some request pending
    logic            launch;    // leaving IDLE this cycle

    assign auto_mode = (mode_q == MODE_AUTO) || (mode_q == MODE_AUTO2);
    assign send_req  = once_q | (auto_mode & (payload_i != snap_q));
    assign launch    = (state_q == IDLE) & send_req;

    // mode and sequence from status writes
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            mode_q <= MODE_OFF;
            seq_q  <= '0;
        end else if (we_i) begin
            mode_q <= status_mode_t'(wd_i[7:6]);
            seq_q  <= status_seq_t'(wd_i[5:0]);
        end
    end

    // send-once pending flag, a new write wins over launch
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            once_q <= 1'b0;
        end else if (we_i) begin
            once_q <= (status_mode_t'(wd_i[7:6]) == MODE_ONCE);
        end else if (launch) begin
            once_q <= 1'b0;
        end
    end

    // payload snapshot, also the reference for auto compare
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            snap_q <= '0;
        end else if (launch) begin
            snap_q <= payload_i;
        end
    end

    // serializer
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (send_req) state_q <= REQ;
                REQ:     if (start_i) state_q <= BYTE1; // wait for grant
                BYTE1:   state_q <= BYTE2;
                BYTE2:   state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    assign rq_o = (state_q == REQ); // drops the cycle after start_i

    always_comb begin
        case (state_q)
            REQ:     ad_o = STATUS_REG_ADDR;
            BYTE1:   ad_o = {seq_q, snap_q[1:0]};  // seq + extra bits
            BYTE2:   ad_o = {1'b0, snap_q[8:2]};   // alive + pwrdwn
            default: ad_o = '0;                    // bus idle
        endcase
    end

endmodule

/* test/clock_ctrl_asserts.sv */
`timescale 1ns/1ps

module clock_ctrl_asserts #(
    parameter clock_ctrl_pkg::cmd_byte_t STATUS_REG_ADDR = 'h3a
) (
    input logic                      mclk,
    input logic                      rst,
    input logic                      cmd_stb_i,      // first command byte
    input logic                      cmd_we_i,       // decoded status write
    input clock_ctrl_pkg::cmd_byte_t status_ad_i,
    input logic                      status_rq_i,
    input logic                      status_start_i
);

    // address byte held for the whole request
    rq_addr: assert property (@(posedge mclk) disable iff (rst)
        status_rq_i |-> status_ad_i == STATUS_REG_ADDR)
        else $error("status bus not at register address during request");

    rq_drop: assert property (@(posedge mclk) disable iff (rst)
        status_rq_i && status_start_i |=> !status_rq_i)
        else $error("status request did not drop after start");

    // four bytes must pass between strobe and write
    cmd_gap: assert property (@(posedge mclk) disable iff (rst)
        cmd_we_i |-> !$past(cmd_stb_i, 1) && !$past(cmd_stb_i, 2) && !$past(cmd_stb_i, 3))
        else $error("command write came too soon after the strobe");

endmodule

bind clock_ctrl_top clock_ctrl_asserts #(
    .STATUS_REG_ADDR (STATUS_REG_ADDR)
) clock_ctrl_asserts_i (
    .mclk           (mclk),
    .rst            (rst),
    .cmd_stb_i      (cmd_stb_i),
    .cmd_we_i       (status_we),
    .status_ad_i    (status_ad_o),
    .status_rq_i    (status_rq_o),
    .status_start_i (status_start_i)
);

/* test/tb_clock_ctrl.sv */
`timescale 1ns/1ps

module tb_clock_ctrl;

    import clock_ctrl_pkg::*;

    localparam cmd_addr_t CLK_ADDR        = 16'h0728;
    localparam cmd_addr_t CLK_MASK        = 16'h07fe;
    localparam cmd_byte_t STATUS_REG_ADDR = 8'h3a;
    localparam int        WINDOW_LOG2     = 8;
    localparam int        WINDOW          = 2 ** WINDOW_LOG2;          // mclk cycles
    localparam int        WATCHDOG_NS     = (40 * WINDOW + 2000) * 4;  // 4 ns per cycle

    logic            mclk = 1'b0;
    logic            rst;
    cmd_byte_t       cmd_ad;
    logic            cmd_stb;
    cmd_byte_t       status_ad;
    logic            status_rq;
    logic            status_start;
    logic [2:0]      mon_clk = 3'b000;  // [0] memclk, [1] ffclk0, [2] ffclk1
    logic [2:0]      clk_en;            // gates for the monitored clocks
    logic [1:0]      extra;
    logic [1:0]      extra_prev;        // extra bits at the previous falling edge
    logic [3:0]      pwrdwn;
    logic            time_ref;
    integer          seed = 32'hb4f7e3d8;
    clk_ctrl_t       ctrl_model;        // last control word written
    status_seq_t     seq_model;         // last sequence number written
    status_payload_t last_payload;      // payload of the last captured packet
    int              pkt_count;

    clock_ctrl_top #(
        .CLK_ADDR (CLK_ADDR), .CLK_MASK (CLK_MASK),
        .STATUS_REG_ADDR (STATUS_REG_ADDR), .WINDOW_LOG2 (WINDOW_LOG2)
    ) clock_ctrl_top_i (
        .mclk (mclk), .rst (rst), .cmd_ad_i (cmd_ad), .cmd_stb_i (cmd_stb),
        .status_ad_o (status_ad), .status_rq_o (status_rq), .status_start_i (status_start),
        .memclk_i (mon_clk[0]), .ffclk0_i (mon_clk[1]), .ffclk1_i (mon_clk[2]),
        .extra_status_i (extra), .pwrdwn_o (pwrdwn), .time_ref_o (time_ref)
    );

    initial begin
        forever #2 mclk = ~mclk;  // 4 ns system clock
    end

    // monitored clocks, frozen while their enable is low
    initial begin
        fork
            forever #5 if (clk_en[0]) mon_clk[0] = ~mon_clk[0];  // 10 ns
            forever #7 if (clk_en[1]) mon_clk[1] = ~mon_clk[1];  // 14 ns
            forever #9 if (clk_en[2]) mon_clk[2] = ~mon_clk[2];  // 18 ns
        join
    end

    always @(negedge mclk) extra_prev <= extra;  // what the snapshot edge saw

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        stop_with_failure("a checked value was wrong");
    endtask

    task automatic check_byte(input cmd_byte_t got, input cmd_byte_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_ctrl(input clk_ctrl_t got, input clk_ctrl_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    // addr byte, {seq, extra}, {0, alive, pwrdwn}
    function automatic logic [23:0] expected_packet(input status_seq_t seq,
                                                    input status_payload_t p);
        return {STATUS_REG_ADDR, seq, p.extra, 1'b0, p.alive, p.pwrdwn};
    endfunction

    // running clocks not held in reset count as alive
    function automatic status_payload_t model_payload(input logic [1:0] x);
        return {clk_en & ~ctrl_model.clk_rst, ctrl_model.pwrdwn, x};
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge mclk);
        #1;  // drive point after the edge
    endtask

    task automatic write_cmd(input cmd_addr_t addr, input cmd_data_t data);
        step(1);
        cmd_stb = 1'b1;         // strobe with addr low only
        cmd_ad  = addr[7:0];
        step(1);
        cmd_stb = 1'b0;
        cmd_ad  = addr[15:8];
        step(1);
        cmd_ad  = data[7:0];
        step(1);
        cmd_ad  = data[15:8];
    endtask

    task automatic write_ctrl(input clk_ctrl_t v);
        write_cmd(CLK_ADDR, {9'd0, v});
        step(1);
        check_ctrl({pwrdwn, clock_ctrl_top_i.ctrl.clk_rst}, ctrl_model, "control before load");
        step(1);                // two cycles after byte 4
        ctrl_model = v;
        check_ctrl({pwrdwn, clock_ctrl_top_i.ctrl.clk_rst}, v, "control word");
    endtask

    task automatic write_status(input status_mode_t mode, input status_seq_t seq);
        write_cmd(CLK_ADDR | 16'h0001, {8'd0, mode, seq});
        seq_model = seq;
    endtask

    task automatic wait_packets(input int n, input int max_cycles);
        int left;
        left = max_cycles;
        while (pkt_count < n) begin
            if (left == 0) begin
                stop_with_failure($sformatf("no status packet within %0d cycles", max_cycles));
            end
            step(1);
            left--;
        end
    endtask

    // answers each request after 0..5 cycles and checks the three bytes
    initial begin
        logic [23:0]     exp;
        status_payload_t pl;
        int              delay;
        @(negedge rst);
        forever begin
            @(negedge mclk);
            if (status_rq) begin
                pl    = model_payload(extra_prev);
                exp   = expected_packet(seq_model, pl);
                delay = $unsigned($random(seed)) % 6;
                check_byte(status_ad, exp[23:16], "status address byte");
                repeat (delay) @(posedge mclk);
                @(posedge mclk);
                #1 status_start = 1'b1;
                @(posedge mclk);
                #1 status_start = 1'b0;
                @(negedge mclk);
                if (status_rq) begin
                    stop_with_failure("status request stayed high after start");
                end
                check_byte(status_ad, exp[15:8], "status byte 1");
                @(negedge mclk);
                check_byte(status_ad, exp[7:0], "status byte 2");
                @(negedge mclk);
                check_byte(status_ad, 8'h00, "status bus after packet");
                last_payload = pl;
                pkt_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("watchdog expired before the tests finished");
    end

    initial begin
        int   n;
        logic cur;
        rst          = 1'b1;
        cmd_ad       = '0;
        cmd_stb      = 1'b0;
        status_start = 1'b0;
        clk_en       = 3'b111;
        extra        = 2'($random(seed));
        ctrl_model   = '0;
        seq_model    = '0;
        pkt_count    = 0;
        repeat (5) @(posedge mclk);
        #1 rst = 1'b0;

        write_ctrl(clk_ctrl_t'{4'b1010, 3'b000});
        write_cmd(CLK_ADDR ^ 16'h0002, 16'h0033);  // outside the mask, dropped
        step(2);
        check_ctrl({pwrdwn, clock_ctrl_top_i.ctrl.clk_rst}, ctrl_model, "control after miss");

        step(3 * WINDOW);                           // alive bits settle
        write_status(MODE_ONCE, 6'h15);
        wait_packets(1, 64);
        step(100);
        check_count(pkt_count, 1, "packets in send-once mode");

        write_status(MODE_AUTO, 6'h2a);
        step(8);
        check_count(pkt_count, 1, "auto packets with no change");
        clk_en[1] = 1'b0;                           // stop ffclk0
        wait_packets(2, 4 * WINDOW);
        clk_en[1] = 1'b1;
        wait_packets(3, 4 * WINDOW);

        write_ctrl(clk_ctrl_t'{4'b1010, 3'b001});   // memclk monitor in reset
        wait_packets(4, 64);
        write_ctrl(clk_ctrl_t'{4'b1010, 3'b000});
        wait_packets(5, 4 * WINDOW);

        for (int i = 0; i < 12; i++) begin
            extra = extra ^ (2'd1 + 2'($unsigned($random(seed)) % 3));  // always a change
            wait_packets(6 + i, 40);
            step($unsigned($random(seed)) % 8);
        end
        for (int i = 0; i < 10; i++) begin
            extra = extra ^ (2'd1 + 2'($unsigned($random(seed)) % 3));
            step(1 + $unsigned($random(seed)) % 3);   // faster than a packet
        end
        step(40);
        if (status_rq) begin
            stop_with_failure("status request still pending after the changes stopped");
        end
        check_byte({6'd0, last_payload.extra}, {6'd0, extra}, "extra bits in last packet");

        for (int e = 0; e < 3; e++) begin
            cur = time_ref;
            n   = 0;
            while (time_ref == cur) begin
                step(1);
                n++;
            end
            if (e > 0) begin
                check_count(n, WINDOW / 2, "time_ref half period");
            end
        end

        step(10);
        $display("TEST OK");
        $finish;
    end

endmodule
